// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    localparam int data_w     = 32;
    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    localparam int hw_int_w   = 8;
    localparam int int_w      = 13;

    localparam logic [int_w-1:0]  ecfg_lie_mask = 13'h1bff;  // LIE bit 10 is reserved
    localparam logic [data_w-1:0] timer_idle    = '1;

    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_num_w-1:0] csr_ecfg   = 14'h004;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;  // SAVE n at csr_save0 + n
    localparam logic [csr_num_w-1:0] csr_tcfg   = 14'h041;
    localparam logic [csr_num_w-1:0] csr_tval   = 14'h042;
    localparam logic [csr_num_w-1:0] csr_ticlr  = 14'h044;

    localparam int crmd_plv_lo       = 0;
    localparam int crmd_ie_bit       = 2;
    localparam int crmd_da_bit       = 3;
    localparam int crmd_pg_bit       = 4;
    localparam int crmd_datf_lo      = 5;
    localparam int crmd_datm_lo      = 7;
    localparam int prmd_pplv_lo      = 0;
    localparam int prmd_pie_bit      = 2;
    localparam int estat_hw_lo       = 2;   // Software bits sit below this
    localparam int estat_rsv_bit     = 10;
    localparam int estat_timer_bit   = 11;
    localparam int estat_ipi_bit     = 12;
    localparam int estat_ecode_lo    = 16;
    localparam int estat_esubcode_lo = 22;
    localparam int eentry_va_lo      = 6;
    localparam int tcfg_en_bit       = 0;
    localparam int tcfg_periodic_bit = 1;
    localparam int tcfg_initval_lo   = 2;
    localparam int ticlr_clr_bit     = 0;

    typedef struct packed {
        logic                 we;
        logic [csr_num_w-1:0] num;
        logic [data_w-1:0]    mask;
        logic [data_w-1:0]    value;
    } csr_wr_t;

    typedef struct packed {
        logic                  valid;
        logic [ecode_w-1:0]    ecode;
        logic [esubcode_w-1:0] esubcode;
        logic [data_w-1:0]     pc;
    } exc_evt_t;

    function automatic logic [data_w-1:0] masked_merge(
        input logic [data_w-1:0] old_val,
        input logic [data_w-1:0] mask,
        input logic [data_w-1:0] new_val
    );
        return (mask & new_val) | (~mask & old_val);
    endfunction

endpackage

`default_nettype wire

// ==== csr_mode_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_mode_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  csr_pkg::csr_wr_t              wr,
    input  csr_pkg::exc_evt_t             exc,
    input  logic                          ertn_flush,
    output logic [csr_pkg::data_w-1:0]    rvalue,
    output logic                          crmd_ie,
    output logic [1:0]                    crmd_plv,
    output logic [csr_pkg::data_w-1:0]    ex_entry,
    output logic [csr_pkg::data_w-1:0]    ertn_entry
);
    import csr_pkg::*;

    logic                           crmd_da;
    logic                           crmd_pg;
    logic [1:0]                     crmd_datf;
    logic [1:0]                     crmd_datm;
    logic [1:0]                     prmd_pplv;
    logic                           prmd_pie;
    logic [data_w-1:0]              era_pc;
    logic [data_w-eentry_va_lo-1:0] eentry_va;

    logic [data_w-1:0] crmd_rd;
    logic [data_w-1:0] prmd_rd;
    logic [data_w-1:0] eentry_rd;
    logic [data_w-1:0] crmd_nxt;
    logic [data_w-1:0] prmd_nxt;
    logic [data_w-1:0] era_nxt;
    logic [data_w-1:0] eentry_nxt;
    logic              wr_crmd;
    logic              wr_prmd;
    logic              wr_era;
    logic              wr_eentry;

    assign wr_crmd   = wr.we && (wr.num == csr_crmd);
    assign wr_prmd   = wr.we && (wr.num == csr_prmd);
    assign wr_era    = wr.we && (wr.num == csr_era);
    assign wr_eentry = wr.we && (wr.num == csr_eentry);

    always_comb begin
        crmd_rd                    = '0;
        crmd_rd[crmd_plv_lo +: 2]  = crmd_plv;
        crmd_rd[crmd_ie_bit]       = crmd_ie;
        crmd_rd[crmd_da_bit]       = crmd_da;
        crmd_rd[crmd_pg_bit]       = crmd_pg;
        crmd_rd[crmd_datf_lo +: 2] = crmd_datf;
        crmd_rd[crmd_datm_lo +: 2] = crmd_datm;
        prmd_rd                    = '0;
        prmd_rd[prmd_pplv_lo +: 2] = prmd_pplv;
        prmd_rd[prmd_pie_bit]      = prmd_pie;
    end

    assign eentry_rd = {eentry_va, {eentry_va_lo{1'b0}}};  // Entry is 64-byte aligned

    assign crmd_nxt   = masked_merge(crmd_rd, wr.mask, wr.value);
    assign prmd_nxt   = masked_merge(prmd_rd, wr.mask, wr.value);
    assign era_nxt    = masked_merge(era_pc, wr.mask, wr.value);
    assign eentry_nxt = masked_merge(eentry_rd, wr.mask, wr.value);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (exc.valid) begin  // Enter kernel with interrupts off
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_nxt[crmd_plv_lo +: 2];
            crmd_ie  <= crmd_nxt[crmd_ie_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_da   <= 1'b1;  // Direct address mode out of reset
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'b0;
            crmd_datm <= 2'b0;
        end else if (wr_crmd) begin
            crmd_da   <= crmd_nxt[crmd_da_bit];
            crmd_pg   <= crmd_nxt[crmd_pg_bit];
            crmd_datf <= crmd_nxt[crmd_datf_lo +: 2];
            crmd_datm <= crmd_nxt[crmd_datm_lo +: 2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
            era_pc    <= '0;
        end else if (exc.valid) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            era_pc    <= exc.pc;
        end else begin
            if (wr_prmd) begin
                prmd_pplv <= prmd_nxt[prmd_pplv_lo +: 2];
                prmd_pie  <= prmd_nxt[prmd_pie_bit];
            end
            if (wr_era) begin
                era_pc <= era_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va <= '0;
        end else if (wr_eentry) begin
            eentry_va <= eentry_nxt[data_w-1:eentry_va_lo];
        end
    end

    always_comb begin
        case (csr_num)
            csr_crmd:   rvalue = crmd_rd;
            csr_prmd:   rvalue = prmd_rd;
            csr_era:    rvalue = era_pc;
            csr_eentry: rvalue = eentry_rd;
            default:    rvalue = '0;
        endcase
    end

    assign ex_entry   = eentry_rd;
    assign ertn_entry = era_pc;

    // Writeback never retires an exception and an ertn together
    a_exc_ertn_excl: assert property (@(posedge clk) disable iff (reset)
        !(exc.valid && ertn_flush))
        else $error("exception and ertn in the same cycle");

endmodule

`default_nettype wire

// ==== csr_int_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_int_status (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  csr_pkg::csr_wr_t              wr,
    input  csr_pkg::exc_evt_t             exc,
    input  logic                          crmd_ie,
    input  logic                          timer_zero,
    input  logic [csr_pkg::hw_int_w-1:0]  hw_int_in,
    input  logic                          ipi_int_in,
    output logic [csr_pkg::data_w-1:0]    rvalue,
    output logic                          has_int
);
    import csr_pkg::*;

    logic [int_w-1:0]      ecfg_lie;
    logic [int_w-1:0]      estat_is;
    logic [ecode_w-1:0]    estat_ecode;
    logic [esubcode_w-1:0] estat_esubcode;

    logic [data_w-1:0] ecfg_rd;
    logic [data_w-1:0] estat_rd;
    logic [data_w-1:0] ecfg_nxt;
    logic [data_w-1:0] estat_nxt;
    logic              wr_ecfg;
    logic              wr_estat;
    logic              ticlr_clr;

    assign wr_ecfg   = wr.we && (wr.num == csr_ecfg);
    assign wr_estat  = wr.we && (wr.num == csr_estat);
    assign ticlr_clr = wr.we && (wr.num == csr_ticlr)
                    && wr.mask[ticlr_clr_bit] && wr.value[ticlr_clr_bit];

    assign ecfg_rd = {{(data_w-int_w){1'b0}}, ecfg_lie};

    always_comb begin
        estat_rd                                  = '0;
        estat_rd[int_w-1:0]                       = estat_is;
        estat_rd[estat_ecode_lo +: ecode_w]       = estat_ecode;
        estat_rd[estat_esubcode_lo +: esubcode_w] = estat_esubcode;
    end

    assign ecfg_nxt  = masked_merge(ecfg_rd, wr.mask, wr.value);
    assign estat_nxt = masked_merge(estat_rd, wr.mask, wr.value);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (wr_ecfg) begin
            ecfg_lie <= ecfg_nxt[int_w-1:0] & ecfg_lie_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is <= '0;
        end else begin
            if (wr_estat) begin
                estat_is[estat_hw_lo-1:0] <= estat_nxt[estat_hw_lo-1:0];  // Software bits
            end
            estat_is[estat_hw_lo +: hw_int_w] <= hw_int_in;
            estat_is[estat_rsv_bit]           <= 1'b0;
            if (timer_zero) begin
                estat_is[estat_timer_bit] <= 1'b1;  // Set wins over TICLR
            end else if (ticlr_clr) begin
                estat_is[estat_timer_bit] <= 1'b0;
            end
            estat_is[estat_ipi_bit] <= ipi_int_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (exc.valid) begin
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
        end
    end

    always_comb begin
        case (csr_num)
            csr_ecfg:  rvalue = ecfg_rd;
            csr_estat: rvalue = estat_rd;
            csr_ticlr: rvalue = '0;  // Write-only clear
            default:   rvalue = '0;
        endcase
    end

    assign has_int = (|(estat_is & ecfg_lie)) && crmd_ie;

    // A timer hit is never lost to a TICLR in the same cycle
    a_timer_set_wins: assert property (@(posedge clk) disable iff (reset)
        timer_zero |=> estat_is[estat_timer_bit])
        else $error("timer bit not set after the counter reached zero");

endmodule

`default_nettype wire

// ==== csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  csr_pkg::csr_wr_t              wr,
    output logic [csr_pkg::data_w-1:0]    rvalue,
    output logic                          timer_zero
);
    import csr_pkg::*;

    logic                              tcfg_en;
    logic                              tcfg_periodic;
    logic [data_w-tcfg_initval_lo-1:0] tcfg_initval;
    logic [data_w-1:0]                 timer_cnt;

    logic [data_w-1:0] tcfg_rd;
    logic [data_w-1:0] tcfg_nxt;
    logic              wr_tcfg;
    logic              load;

    assign wr_tcfg  = wr.we && (wr.num == csr_tcfg);
    assign tcfg_rd  = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_nxt = masked_merge(tcfg_rd, wr.mask, wr.value);
    assign load     = wr_tcfg && tcfg_nxt[tcfg_en_bit];  // Start from the new INITVAL

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_tcfg) begin
            tcfg_en       <= tcfg_nxt[tcfg_en_bit];
            tcfg_periodic <= tcfg_nxt[tcfg_periodic_bit];
            tcfg_initval  <= tcfg_nxt[data_w-1:tcfg_initval_lo];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= timer_idle;
        end else if (load) begin
            timer_cnt <= {tcfg_nxt[data_w-1:tcfg_initval_lo], {tcfg_initval_lo{1'b0}}};
        end else if (tcfg_en && (timer_cnt != timer_idle)) begin
            if (timer_cnt == '0) begin
                timer_cnt <= tcfg_periodic ? {tcfg_initval, {tcfg_initval_lo{1'b0}}}
                                           : timer_idle;  // One-shot parks at idle
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    assign timer_zero = (timer_cnt == '0);

    always_comb begin
        case (csr_num)
            csr_tcfg: rvalue = tcfg_rd;
            csr_tval: rvalue = timer_cnt;
            default:  rvalue = '0;
        endcase
    end

    a_cnt_hold: assert property (@(posedge clk) disable iff (reset)
        (!tcfg_en && !load) |=> $stable(timer_cnt))
        else $error("timer counter moved while disabled");

endmodule

`default_nettype wire

// ==== csr_scratch.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_scratch #(
    parameter int num_save = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  csr_pkg::csr_wr_t              wr,
    output logic [csr_pkg::data_w-1:0]    rvalue
);
    import csr_pkg::*;

    logic [num_save-1:0][data_w-1:0] save_rd;

    for (genvar i = 0; i < num_save; i++) begin : g_save
        localparam logic [csr_num_w-1:0] save_num = csr_save0 + csr_num_w'(i);

        logic [data_w-1:0] save_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                save_q <= '0;
            end else if (wr.we && (wr.num == save_num)) begin
                save_q <= masked_merge(save_q, wr.mask, wr.value);
            end
        end

        assign save_rd[i] = (csr_num == save_num) ? save_q : '0;
    end

    // At most one entry matches the read address
    always_comb begin
        rvalue = '0;
        for (int i = 0; i < num_save; i++) begin
            rvalue = rvalue | save_rd[i];
        end
    end

endmodule

`default_nettype wire

// ==== csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter int num_save = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  csr_pkg::csr_wr_t              wr,
    input  csr_pkg::exc_evt_t             exc,
    input  logic                          ertn_flush,
    input  logic [csr_pkg::hw_int_w-1:0]  hw_int_in,
    input  logic                          ipi_int_in,
    output logic [csr_pkg::data_w-1:0]    csr_rvalue,
    output logic                          has_int,
    output logic [csr_pkg::data_w-1:0]    ex_entry,
    output logic [csr_pkg::data_w-1:0]    ertn_entry,
    output logic [1:0]                    crmd_plv
);
    import csr_pkg::*;

    logic [data_w-1:0] mode_rvalue;
    logic [data_w-1:0] int_rvalue;
    logic [data_w-1:0] timer_rvalue;
    logic [data_w-1:0] save_rvalue;
    logic              crmd_ie;
    logic              timer_zero;

    csr_mode_ctrl u_mode_ctrl (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .wr         (wr),
        .exc        (exc),
        .ertn_flush (ertn_flush),
        .rvalue     (mode_rvalue),
        .crmd_ie    (crmd_ie),
        .crmd_plv   (crmd_plv),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry)
    );

    csr_int_status u_int_status (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .wr         (wr),
        .exc        (exc),
        .crmd_ie    (crmd_ie),
        .timer_zero (timer_zero),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .rvalue     (int_rvalue),
        .has_int    (has_int)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .wr         (wr),
        .rvalue     (timer_rvalue),
        .timer_zero (timer_zero)
    );

    csr_scratch #(
        .num_save (num_save)
    ) u_scratch (
        .clk    (clk),
        .reset  (reset),
        .csr_num(csr_num),
        .wr     (wr),
        .rvalue (save_rvalue)
    );

    // Unselected blocks return zero
    assign csr_rvalue = mode_rvalue | int_rvalue | timer_rvalue | save_rvalue;

endmodule

`default_nettype wire

// ==== tb_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_file;
    import csr_pkg::*;

    localparam int test_cycles    = 400;  // Rough length of the whole sequence
    localparam int timeout_cycles = 5 * test_cycles;

    logic                 clk;
    logic                 reset;
    logic [csr_num_w-1:0] csr_num;
    csr_wr_t              wr;
    exc_evt_t             exc;
    logic                 ertn_flush;
    logic [hw_int_w-1:0]  hw_int_in;
    logic                 ipi_int_in;
    logic [data_w-1:0]    csr_rvalue;
    logic                 has_int;
    logic [data_w-1:0]    ex_entry;
    logic [data_w-1:0]    ertn_entry;
    logic [1:0]           crmd_plv;
    int                   checks;
    int                   errors;

    csr_file #(.num_save(4)) dut (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .wr         (wr),
        .exc        (exc),
        .ertn_flush (ertn_flush),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .csr_rvalue (csr_rvalue),
        .has_int    (has_int),
        .ex_entry   (ex_entry),
        .ertn_entry (ertn_entry),
        .crmd_plv   (crmd_plv)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the tests were still running after %0d cycles", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [data_w-1:0] merge_bits(
        input logic [data_w-1:0] old_val,
        input logic [data_w-1:0] mask,
        input logic [data_w-1:0] new_val
    );
        logic [data_w-1:0] result;
        for (int b = 0; b < data_w; b++) begin
            if (mask[b]) begin
                result[b] = new_val[b];
            end else begin
                result[b] = old_val[b];
            end
        end
        return result;
    endfunction

    task automatic check_val(input string what, input logic [data_w-1:0] got,
                             input logic [data_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_csr(input logic [csr_num_w-1:0] num, input logic [data_w-1:0] mask,
                             input logic [data_w-1:0] value);
        @(posedge clk);
        wr <= '{we: 1'b1, num: num, mask: mask, value: value};
        @(posedge clk);
        wr.we <= 1'b0;
    endtask

    task automatic read_csr(input logic [csr_num_w-1:0] num, output logic [data_w-1:0] data);
        @(posedge clk);
        csr_num <= num;
        @(negedge clk);
        data = csr_rvalue;
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%-20s finished, %0d errors", name, errors - err_before);
    endtask

    task automatic test_masked_writes();
        logic [csr_num_w-1:0] addr [6];
        logic [data_w-1:0]    model [6];
        logic [data_w-1:0]    val;
        logic [data_w-1:0]    mask;
        logic [data_w-1:0]    got;
        int                   err0;
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            addr[i] = csr_save0 + 14'(i);
        end
        addr[4] = csr_eentry;
        addr[5] = csr_era;
        for (int i = 0; i < 6; i++) begin
            model[i] = '0;
        end
        for (int round = 0; round < 4; round++) begin
            for (int r = 0; r < 6; r++) begin
                val  = $urandom;
                mask = $urandom;
                write_csr(addr[r], mask, val);
                model[r] = merge_bits(model[r], mask, val);
                if (r == 4) begin
                    model[r][5:0] = 6'b0;  // EENTRY is 64-byte aligned
                end
            end
            for (int r = 0; r < 6; r++) begin
                read_csr(addr[r], got);
                check_val($sformatf("CSR %h", addr[r]), got, model[r]);
                if (r == 4) begin
                    check_val("EENTRY low bits", {26'b0, got[5:0]}, 32'h0);
                end
            end
            check_val("ex_entry", ex_entry, model[4]);
        end
        report_test("masked_writes", err0);
    endtask

    task automatic test_exception_return();
        logic [data_w-1:0]     pc;
        logic [data_w-1:0]     tmp;
        logic [data_w-1:0]     got;
        logic [ecode_w-1:0]    ec;
        logic [esubcode_w-1:0] sc;
        int                    err0;
        err0 = errors;
        write_csr(csr_crmd, 32'h7, 32'h7);  // PLV 3, IE 1
        pc  = $urandom;
        tmp = $urandom;
        ec  = tmp[5:0];
        sc  = tmp[16:8];
        @(posedge clk);
        exc <= '{valid: 1'b1, ecode: ec, esubcode: sc, pc: pc};
        @(posedge clk);
        exc.valid <= 1'b0;
        @(negedge clk);
        check_val("crmd_plv after exception", {30'b0, crmd_plv}, 32'h0);
        read_csr(csr_crmd, got);
        check_val("CRMD PLV/IE after exception", got & 32'h7, 32'h0);
        read_csr(csr_prmd, got);
        check_val("PRMD PPLV/PIE", got & 32'h7, 32'h7);
        read_csr(csr_era, got);
        check_val("ERA", got, pc);
        check_val("ertn_entry", ertn_entry, pc);
        read_csr(csr_estat, got);
        check_val("ESTAT code fields", {17'b0, got[30:16]}, {17'b0, sc, ec});
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
        @(negedge clk);
        check_val("crmd_plv after ertn", {30'b0, crmd_plv}, 32'h3);
        read_csr(csr_crmd, got);
        check_val("CRMD PLV/IE after ertn", got & 32'h7, 32'h7);
        report_test("exception_return", err0);
    endtask

    task automatic test_interrupt_gating();
        logic [data_w-1:0] got;
        int                err0;
        err0 = errors;
        write_csr(csr_ecfg, '1, 32'h4);  // LIE for hardware line 0
        @(posedge clk);
        hw_int_in <= 8'h01;
        @(posedge clk);
        @(negedge clk);
        check_val("has_int, LIE and IE set", {31'b0, has_int}, 32'h1);
        write_csr(csr_ecfg, '1, 32'h0);
        @(negedge clk);
        check_val("has_int, LIE clear", {31'b0, has_int}, 32'h0);
        write_csr(csr_ecfg, '1, 32'h4);
        write_csr(csr_crmd, 32'h4, 32'h0);
        @(negedge clk);
        check_val("has_int, IE clear", {31'b0, has_int}, 32'h0);
        @(posedge clk);
        hw_int_in <= '0;
        write_csr(csr_crmd, 32'h4, 32'h4);
        write_csr(csr_ecfg, '1, 32'h1);
        @(negedge clk);
        check_val("has_int, nothing pending", {31'b0, has_int}, 32'h0);
        write_csr(csr_estat, 32'h3, 32'h1);  // Software interrupt 0
        @(negedge clk);
        check_val("has_int, software bit", {31'b0, has_int}, 32'h1);
        write_csr(csr_estat, 32'h3, 32'h0);
        write_csr(csr_ecfg, '1, 32'h1fff);
        read_csr(csr_ecfg, got);
        check_val("ECFG LIE", got, 32'h1fff & ~(32'h1 << 10));
        write_csr(csr_ecfg, '1, 32'h0);
        report_test("interrupt_gating", err0);
    endtask

    task automatic poll_tval_zero(input logic [data_w-1:0] start);
        logic [data_w-1:0] prev;
        logic [data_w-1:0] got;
        int                polls;
        prev  = start + 1;
        polls = 0;
        got   = '1;
        @(posedge clk);
        csr_num <= csr_tval;
        while (got != '0 && polls < 200) begin
            @(negedge clk);
            got = csr_rvalue;
            polls++;
            checks++;
            if (got >= prev) begin
                errors++;
                $display("[FAIL] %0t: TVAL went from %h to %h", $time, prev, got);
            end
            prev = got;
        end
        checks++;
        if (got != '0) begin
            errors++;
            $display("TVAL did not reach zero within %0d polls", polls);
        end
    endtask

    task automatic test_one_shot_timer();
        logic [data_w-1:0] got;
        int                err0;
        err0 = errors;
        write_csr(csr_tcfg, '1, (32'd5 << 2) | 32'h1);
        poll_tval_zero(32'd5 * 4);
        read_csr(csr_estat, got);
        check_val("ESTAT timer bit set", {31'b0, got[11]}, 32'h1);
        read_csr(csr_tval, got);
        check_val("TVAL idle", got, 32'hffff_ffff);
        repeat (6) @(posedge clk);
        read_csr(csr_tval, got);
        check_val("TVAL still idle", got, 32'hffff_ffff);
        write_csr(csr_ticlr, 32'h1, 32'h1);
        read_csr(csr_estat, got);
        check_val("ESTAT timer bit cleared", {31'b0, got[11]}, 32'h0);
        report_test("one_shot_timer", err0);
    endtask

    task automatic test_periodic_timer();
        logic [data_w-1:0] got;
        int                err0;
        err0 = errors;
        write_csr(csr_tcfg, '1, (32'd3 << 2) | 32'h3);
        poll_tval_zero(32'd3 * 4);
        @(negedge clk);
        check_val("TVAL reload", csr_rvalue, 32'd3 * 4);
        read_csr(csr_estat, got);
        check_val("ESTAT timer bit set", {31'b0, got[11]}, 32'h1);
        write_csr(csr_ticlr, 32'h1, 32'h1);
        read_csr(csr_estat, got);
        check_val("ESTAT timer bit cleared", {31'b0, got[11]}, 32'h0);
        poll_tval_zero(32'd3 * 4);
        read_csr(csr_estat, got);
        check_val("ESTAT timer bit set again", {31'b0, got[11]}, 32'h1);
        write_csr(csr_tcfg, '1, 32'h0);
        write_csr(csr_ticlr, 32'h1, 32'h1);
        report_test("periodic_timer", err0);
    endtask

    initial begin
        logic [data_w-1:0] got;
        void'($urandom(32'hd1506844));
        checks     = 0;
        errors     = 0;
        reset      = 1'b1;
        csr_num    = '0;
        wr         = '0;
        exc        = '0;
        ertn_flush = 1'b0;
        hw_int_in  = '0;
        ipi_int_in = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_val("has_int after reset", {31'b0, has_int}, 32'h0);
        check_val("crmd_plv after reset", {30'b0, crmd_plv}, 32'h0);
        read_csr(csr_crmd, got);
        check_val("CRMD after reset", got, 32'h8);  // Only DA set
        test_masked_writes();
        test_exception_return();
        test_interrupt_gating();
        test_one_shot_timer();
        test_periodic_timer();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
csr_pkg.sv
csr_mode_ctrl.sv
csr_int_status.sv
csr_timer.sv
csr_scratch.sv
csr_file.sv
tb_csr_file.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CSR file testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_file \
    -f filelist.f -o sim_csr_file > build.log 2>&1 \
    && ./obj_dir/sim_csr_file > sim.log 2>&1 \
    || echo "Build or simulation stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0
